/* common/vu_consts.svh */
// Widths, FIFO depths and register map of the vector-lane arithmetic unit
`ifndef VU_CONSTS_SVH
`define VU_CONSTS_SVH

// Operand width in bits
`define VU_DATA_W		16

// Queue depths
`define VU_REQ_DEPTH	4
`define VU_RES_DEPTH	8

// ALU stages, also the credit reserve in the result FIFO
`define VU_PIPE_DEPTH	2

// Word addresses on the Wishbone port
`define VU_ADR_OPA		4'd0
`define VU_ADR_ADD		4'd1
`define VU_ADR_SUB		4'd2
`define VU_ADR_MIN		4'd3
`define VU_ADR_MAX		4'd4
`define VU_ADR_RES		4'd5
`define VU_ADR_STAT		4'd6
`define VU_ADR_CTRL		4'd7

`endif

/* common/vu_pkg.sv */
// Shared types for the vector-lane unit: operations, payloads and Wishbone bundles
`default_nettype none

`include "vu_consts.svh"

package vu_pkg;

	// Lane operation, picked by the write address
	typedef enum logic [1:0]
	{
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MIN = 2'd2,
		OP_MAX = 2'd3
	} vu_op_t;

	// One queued request
	typedef struct packed
	{
		vu_op_t op;
		logic [`VU_DATA_W-1:0] a;
		logic [`VU_DATA_W-1:0] b;
	} vu_req_t;

	// Result word
	// Bit 16 carries the carry or borrow for add and sub
	typedef struct packed
	{
		logic [`VU_DATA_W:0] value;
	} vu_res_t;

	// Host to slave, classic single cycles only
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	// Slave to host
	typedef struct packed
	{
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

/* source/sram_1r1w.sv */
// Inferred memory with one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

module sram_1r1w
	#(parameter type T = logic [31:0],
	parameter int NUM_ENTRIES = 4)
	(input logic clk,
	input logic [$clog2(NUM_ENTRIES)-1:0] rd_addr_i,
	output T rd_data_o,
	input logic wr_en_i,
	input logic [$clog2(NUM_ENTRIES)-1:0] wr_addr_i,
	input T wr_data_i);

	// Storage array, contents undefined until written
	T mem [NUM_ENTRIES];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// Read port
	// A write to the address being read is forwarded, so a word pushed
	// into an empty FIFO shows up on the next cycle
	always_ff @(posedge clk)
	begin
		if (wr_en_i && wr_addr_i == rd_addr_i)
			rd_data_o <= wr_data_i;
		else
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

/* fifo/sync_fifo.sv */
// Synchronous circular FIFO on a 1R1W memory with flush, full, almost-full and empty
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
	#(parameter type T = logic [31:0],
	parameter int NUM_ENTRIES = 4,
	parameter int ALMOST_FULL_THRESHOLD = 1)
	(input logic clk,
	input logic reset,
	input logic flush_i,
	input logic enqueue_i,
	input logic dequeue_i,
	input T value_i,
	output T value_o,
	output logic full_o,
	output logic almost_full_o,
	output logic empty_o);

	localparam int ADDR_W = $clog2(NUM_ENTRIES);

	// Pointer wrap point and flag levels
	localparam logic [ADDR_W-1:0] LAST_IDX = ADDR_W'(NUM_ENTRIES - 1);
	localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(NUM_ENTRIES);
	localparam logic [ADDR_W:0] AF_COUNT = (ADDR_W + 1)'(NUM_ENTRIES - ALMOST_FULL_THRESHOLD);

	logic [ADDR_W-1:0] head_ff;
	logic [ADDR_W-1:0] head_nxt;
	logic [ADDR_W-1:0] tail_ff;
	logic [ADDR_W-1:0] tail_nxt;
	logic [ADDR_W:0] count_ff;
	logic [ADDR_W:0] count_nxt;

	// Read address is the next head
	// so value_o already holds the new head entry after a pop
	sram_1r1w #(
		.T(T),
		.NUM_ENTRIES(NUM_ENTRIES)
	) fifo_data (
		.clk(clk),
		.rd_addr_i(head_nxt),
		.rd_data_o(value_o),
		.wr_en_i(enqueue_i),
		.wr_addr_i(tail_ff),
		.wr_data_i(value_i));

	// Next pointers and occupancy
	always_comb
	begin
		head_nxt = head_ff;
		tail_nxt = tail_ff;
		count_nxt = count_ff;

		if (flush_i)
		begin
			// Drop everything, a push in the same cycle is lost too
			head_nxt = '0;
			tail_nxt = '0;
			count_nxt = '0;
		end
		else
		begin
			if (enqueue_i)
			begin
				if (tail_ff == LAST_IDX)
					tail_nxt = '0;
				else
					tail_nxt = tail_ff + 1'b1;
			end

			if (dequeue_i)
			begin
				if (head_ff == LAST_IDX)
					head_nxt = '0;
				else
					head_nxt = head_ff + 1'b1;
			end

			// Simultaneous push and pop leaves the count alone
			if (enqueue_i && !dequeue_i)
				count_nxt = count_ff + 1'b1;
			else if (dequeue_i && !enqueue_i)
				count_nxt = count_ff - 1'b1;
		end
	end

	// State and flags, all registered from the next count
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			head_ff <= '0;
			tail_ff <= '0;
			count_ff <= '0;
			full_o <= 1'b0;
			almost_full_o <= 1'b0;
			empty_o <= 1'b1;
		end
		else
		begin
			head_ff <= head_nxt;
			tail_ff <= tail_nxt;
			count_ff <= count_nxt;
			full_o <= count_nxt == FULL_COUNT;
			// Reserve of ALMOST_FULL_THRESHOLD slots left
			almost_full_o <= count_nxt >= AF_COUNT;
			empty_o <= count_nxt == '0;
		end
	end

endmodule

`default_nettype wire

/* source/wb_slave_port.sv */
// Wishbone classic slave: operand A register, request push, result pop and status
`timescale 1ns/1ps
`default_nettype none

`include "vu_consts.svh"

module wb_slave_port
	import vu_pkg::*;
	(input logic clk,
	input logic reset,
	input wb_req_t wb_i,
	output wb_rsp_t wb_o,
	input logic req_full_i,
	input logic req_empty_i,
	input logic res_full_i,
	input logic res_empty_i,
	output logic req_enqueue_o,
	output vu_req_t req_o,
	output logic res_dequeue_o,
	input vu_res_t res_i,
	output logic flush_o);

	logic access;
	logic is_op_adr;
	logic accept;
	logic accept_wr;
	logic accept_rd;
	vu_op_t op_d;
	logic [31:0] rd_data;
	logic ack_q;
	logic enq_q;
	logic deq_q;
	logic flush_q;
	logic [`VU_DATA_W-1:0] opa_q;
	vu_req_t req_q;
	logic [31:0] dat_q;

	// New access pending, the ack of the previous one has gone
	assign access = wb_i.cyc && wb_i.stb && !ack_q;

	// Operation from the write address
	always_comb
	begin
		is_op_adr = 1'b1;
		op_d = OP_ADD;
		case (wb_i.adr)
			`VU_ADR_ADD: op_d = OP_ADD;
			`VU_ADR_SUB: op_d = OP_SUB;
			`VU_ADR_MIN: op_d = OP_MIN;
			`VU_ADR_MAX: op_d = OP_MAX;
			default: is_op_adr = 1'b0;
		endcase
	end

	// Op writes wait while the request FIFO is full
	assign accept = access && !(wb_i.we && is_op_adr && req_full_i);
	assign accept_wr = accept && wb_i.we;
	assign accept_rd = accept && !wb_i.we;

	// Read mux
	always_comb
	begin
		rd_data = '0;
		case (wb_i.adr)
			`VU_ADR_RES:
			begin
				// Empty FIFO reads back as zero with the valid flag clear
				if (!res_empty_i)
				begin
					rd_data[31] = 1'b1;
					rd_data[`VU_DATA_W:0] = res_i.value;
				end
			end
			`VU_ADR_STAT: rd_data[3:0] = {res_full_i, res_empty_i, req_full_i, req_empty_i};
			default: rd_data = '0;
		endcase
	end

	// Ack and the strobes that share its cycle
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ack_q <= 1'b0;
			enq_q <= 1'b0;
			deq_q <= 1'b0;
			flush_q <= 1'b0;
			opa_q <= '0;
		end
		else
		begin
			ack_q <= accept;
			enq_q <= accept_wr && is_op_adr;
			// Pop only what was actually returned
			deq_q <= accept_rd && wb_i.adr == `VU_ADR_RES && !res_empty_i;
			flush_q <= accept_wr && wb_i.adr == `VU_ADR_CTRL && wb_i.dat[0];
			if (accept_wr && wb_i.adr == `VU_ADR_OPA)
				opa_q <= wb_i.dat[`VU_DATA_W-1:0];
		end
	end

	// Request payload and read data
	always_ff @(posedge clk)
	begin
		if (accept_wr && is_op_adr)
		begin
			req_q.op <= op_d;
			req_q.a <= opa_q;
			req_q.b <= wb_i.dat[`VU_DATA_W-1:0];
		end
		if (accept_rd)
			dat_q <= rd_data;
	end

	assign req_enqueue_o = enq_q;
	assign req_o = req_q;
	assign res_dequeue_o = deq_q;
	assign flush_o = flush_q;

	always_comb
	begin
		wb_o.ack = ack_q;
		wb_o.dat = dat_q;
	end

endmodule

`default_nettype wire

/* source/alu_pipe.sv */
// Two-stage lane ALU with credit-based issue from the request FIFO
`timescale 1ns/1ps
`default_nettype none

`include "vu_consts.svh"

module alu_pipe
	import vu_pkg::*;
	(input logic clk,
	input logic reset,
	input logic flush_i,
	input logic req_empty_i,
	input vu_req_t req_i,
	output logic req_dequeue_o,
	input logic res_almost_full_i,
	output logic res_valid_o,
	output vu_res_t res_o);

	// Stage 1 contents
	typedef struct packed
	{
		vu_op_t op;
		logic [`VU_DATA_W-1:0] a;
		logic [`VU_DATA_W-1:0] b;
		logic [`VU_DATA_W:0] diff;
		logic a_lt_b;
	} stage1_t;

	logic issue;
	stage1_t s1_d;
	stage1_t s1_q;
	logic s1_valid;
	logic [`VU_DATA_W:0] sum;
	logic [`VU_DATA_W:0] s2_value_d;
	vu_res_t s2_q;
	logic s2_valid;

	// Issue only with a free result slot for every item in flight
	assign issue = !req_empty_i && !res_almost_full_i && !flush_i;
	assign req_dequeue_o = issue;

	// Stage 1 compute, compare and difference from the FIFO head
	always_comb
	begin
		s1_d.op = req_i.op;
		s1_d.a = req_i.a;
		s1_d.b = req_i.b;
		// Borrow lands in the top bit
		s1_d.diff = {1'b0, req_i.a} - {1'b0, req_i.b};
		s1_d.a_lt_b = req_i.a < req_i.b;
	end

	// Stage 2 select
	assign sum = {1'b0, s1_q.a} + {1'b0, s1_q.b};

	always_comb
	begin
		case (s1_q.op)
			OP_ADD: s2_value_d = sum;
			OP_SUB: s2_value_d = s1_q.diff;
			OP_MIN: s2_value_d = {1'b0, s1_q.a_lt_b ? s1_q.a : s1_q.b};
			default: s2_value_d = {1'b0, s1_q.a_lt_b ? s1_q.b : s1_q.a};
		endcase
	end

	// Valid bits, cleared by flush
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else if (flush_i)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= issue;
			s2_valid <= s1_valid;
		end
	end

	// Data registers
	always_ff @(posedge clk)
	begin
		if (issue)
			s1_q <= s1_d;
		if (s1_valid)
			s2_q.value <= s2_value_d;
	end

	assign res_valid_o = s2_valid;
	assign res_o = s2_q;

endmodule

`default_nettype wire

/* source/vu_top.sv */
// Vector-lane unit top: Wishbone port, request and result FIFOs, ALU pipeline
`timescale 1ns/1ps
`default_nettype none

`include "vu_consts.svh"

module vu_top
	import vu_pkg::*;
	(input logic clk,
	input logic reset,
	input wb_req_t wb_i,
	output wb_rsp_t wb_o);

	logic flush;

	// Request side
	logic req_enqueue;
	logic req_dequeue;
	logic req_full;
	logic req_empty;
	vu_req_t req_in;
	vu_req_t req_out;

	// Result side
	logic res_enqueue;
	logic res_dequeue;
	logic res_full;
	logic res_almost_full;
	logic res_empty;
	vu_res_t res_in;
	vu_res_t res_out;

	wb_slave_port port (
		.clk(clk),
		.reset(reset),
		.wb_i(wb_i),
		.wb_o(wb_o),
		.req_full_i(req_full),
		.req_empty_i(req_empty),
		.res_full_i(res_full),
		.res_empty_i(res_empty),
		.req_enqueue_o(req_enqueue),
		.req_o(req_in),
		.res_dequeue_o(res_dequeue),
		.res_i(res_out),
		.flush_o(flush));

	// Request queue, only full and empty are used
	sync_fifo #(
		.T(vu_req_t),
		.NUM_ENTRIES(`VU_REQ_DEPTH)
	) req_fifo (
		.clk(clk),
		.reset(reset),
		.flush_i(flush),
		.enqueue_i(req_enqueue),
		.dequeue_i(req_dequeue),
		.value_i(req_in),
		.value_o(req_out),
		.full_o(req_full),
		.almost_full_o(),
		.empty_o(req_empty));

	alu_pipe alu (
		.clk(clk),
		.reset(reset),
		.flush_i(flush),
		.req_empty_i(req_empty),
		.req_i(req_out),
		.req_dequeue_o(req_dequeue),
		.res_almost_full_i(res_almost_full),
		.res_valid_o(res_enqueue),
		.res_o(res_in));

	// Result queue, almost-full reserves one slot per ALU stage
	sync_fifo #(
		.T(vu_res_t),
		.NUM_ENTRIES(`VU_RES_DEPTH),
		.ALMOST_FULL_THRESHOLD(`VU_PIPE_DEPTH)
	) res_fifo (
		.clk(clk),
		.reset(reset),
		.flush_i(flush),
		.enqueue_i(res_enqueue),
		.dequeue_i(res_dequeue),
		.value_i(res_in),
		.value_o(res_out),
		.full_o(res_full),
		.almost_full_o(res_almost_full),
		.empty_o(res_empty));

endmodule

`default_nettype wire

/* bench/fifo_assert.sv */
// FIFO protocol checks, bound into every sync_fifo instance
`timescale 1ns/1ps
`default_nettype none

module fifo_assert
	(input logic clk,
	input logic reset,
	input logic enqueue_i,
	input logic dequeue_i,
	input logic full_i,
	input logic almost_full_i,
	input logic empty_i);

	// A push into a full FIFO would overwrite the head
	no_push_when_full: assert property (@(posedge clk) disable iff (reset)
		!(enqueue_i && full_i))
		else $error("enqueue while the FIFO is full");

	// A pop from an empty FIFO would corrupt the count
	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
		!(dequeue_i && empty_i))
		else $error("dequeue while the FIFO is empty");

	// Full is the top of the almost-full range
	full_implies_almost_full: assert property (@(posedge clk) disable iff (reset)
		full_i |-> almost_full_i)
		else $error("full set without almost_full");

endmodule

bind sync_fifo fifo_assert fifo_checks (
	.clk(clk),
	.reset(reset),
	.enqueue_i(enqueue_i),
	.dequeue_i(dequeue_i),
	.full_i(full_o),
	.almost_full_i(almost_full_o),
	.empty_i(empty_o));

`default_nettype wire

/* bench/vu_tb.sv */
// Random testbench for the vector-lane unit checked against a result queue model
`timescale 1ns/1ps
`default_nettype none

`include "vu_consts.svh"

module vu_tb
	import vu_pkg::*;
	();

	localparam int NUM_ROUNDS = 12;

	// Bus accesses per phase with generous room for status polls
	localparam int PLANNED_ACCESSES = 2
		+ NUM_ROUNDS * 3 * 6
		+ 59
		+ 13
		+ 18;
	localparam int TIMEOUT_CYCLES = 40 * PLANNED_ACCESSES;

	logic clk;
	logic reset;
	wb_req_t bus_req;
	wb_rsp_t bus_rsp;

	logic [15:0] lfsr_state;
	int cycle_count = 0;

	// Expected results in request order
	vu_res_t model_q[$];
	// Mirror of the operand A register
	logic [`VU_DATA_W-1:0] opa_model;

	vu_top DUT (
		.clk(clk),
		.reset(reset),
		.wb_i(bus_req),
		.wb_o(bus_rsp));

	initial
		clk = 1'b0;

	always #5 clk = ~clk;

	// Galois step for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	// Returns n fresh bits with one LFSR step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Reference result from integer arithmetic on the unsigned operands
	function automatic vu_res_t model_result(input vu_op_t op, input logic [15:0] a,
		input logic [15:0] b);
		int ai;
		int bi;
		int r;
		vu_res_t res;
		ai = {16'b0, a};
		bi = {16'b0, b};
		case (op)
			OP_ADD: r = ai + bi;
			// Negative difference leaves the borrow in bit 16
			OP_SUB: r = ai - bi;
			OP_MIN: r = (ai < bi) ? ai : bi;
			default: r = (ai > bi) ? ai : bi;
		endcase
		res.value = r[16:0];
		return res;
	endfunction

	// Write address for each operation
	function automatic logic [3:0] op_address(input vu_op_t op);
		logic [3:0] adr;
		case (op)
			OP_ADD: adr = `VU_ADR_ADD;
			OP_SUB: adr = `VU_ADR_SUB;
			OP_MIN: adr = `VU_ADR_MIN;
			default: adr = `VU_ADR_MAX;
		endcase
		return adr;
	endfunction

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	// One classic cycle held until ack
	// Waits counts the edges without ack
	task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat, output int waits);
		logic acked;
		@(posedge clk);
		#1;
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = we;
		bus_req.adr = adr;
		bus_req.dat = wdat;
		acked = 1'b0;
		waits = 0;
		while (!acked)
		begin
			@(posedge clk);
			#1;
			if (bus_rsp.ack)
				acked = 1'b1;
			else
				waits++;
		end
		rdat = bus_rsp.dat;
		// Drop the strobe on the cycle after ack
		bus_req.cyc = 1'b0;
		bus_req.stb = 1'b0;
		bus_req.we = 1'b0;
	endtask

	task automatic set_operand_a(input logic [15:0] a);
		logic [31:0] rdat;
		int waits;
		bus_access(1'b1, `VU_ADR_OPA, {16'b0, a}, rdat, waits);
		opa_model = a;
	endtask

	// Op write that queues its expected value once the request is taken
	task automatic send_request(input vu_op_t op, input logic [15:0] b, output int waits);
		logic [31:0] rdat;
		bus_access(1'b1, op_address(op), {16'b0, b}, rdat, waits);
		model_q.push_back(model_result(op, opa_model, b));
	endtask

	task automatic send_random_request(output int waits);
		logic [31:0] bits;
		vu_op_t op;
		bits = random_bits(2);
		op = vu_op_t'(bits[1:0]);
		bits = random_bits(16);
		send_request(op, bits[15:0], waits);
	endtask

	task automatic read_status(output logic [31:0] stat);
		int waits;
		bus_access(1'b0, `VU_ADR_STAT, '0, stat, waits);
	endtask

	task automatic check_res(input vu_res_t got, input logic got_valid, input vu_res_t want,
		input logic want_valid);
		if (got !== want || got_valid !== want_valid)
		begin
			$display("Error at %0t: result %h valid %b, expected %h valid %b",
				$time, got.value, got_valid, want.value, want_valid);
			abort_run();
		end
	endtask

	task automatic check_stat(input logic [31:0] got, input logic req_empty,
		input logic req_full, input logic res_empty, input logic res_full);
		logic [31:0] want;
		want = {28'b0, res_full, res_empty, req_full, req_empty};
		if (got !== want)
		begin
			$display("Error at %0t: status %h, expected %h", $time, got, want);
			abort_run();
		end
	endtask

	// Wait for a result, pop it and compare with the oldest model entry
	task automatic read_and_check_result();
		logic [31:0] stat;
		logic [31:0] rdat;
		int waits;
		stat = 32'h4;
		while (stat[2])
			read_status(stat);
		bus_access(1'b0, `VU_ADR_RES, '0, rdat, waits);
		check_res(vu_res_t'(rdat[`VU_DATA_W:0]), rdat[31], model_q.pop_front(), 1'b1);
	endtask

	// Empty result FIFO reads back as zero with valid clear
	task automatic check_empty_read();
		logic [31:0] rdat;
		int waits;
		bus_access(1'b0, `VU_ADR_RES, '0, rdat, waits);
		check_res(vu_res_t'(rdat[`VU_DATA_W:0]), rdat[31], '0, 1'b0);
	endtask

	// Run limit
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	initial
	begin
		logic [31:0] bits;
		logic [31:0] stat;
		int waits;
		int burst;
		vu_op_t op;
		lfsr_state = 16'd12;
		bus_req = '0;
		opa_model = '0;
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		// Idle state after reset
		read_status(stat);
		check_stat(stat, 1'b1, 1'b0, 1'b1, 1'b0);
		check_empty_read();

		// Random ops in short bursts with a fresh operand A per op
		for (int r = 0; r < NUM_ROUNDS; r++)
		begin
			bits = random_bits(2);
			burst = bits % 3 + 1;
			for (int j = 0; j < burst; j++)
			begin
				bits = random_bits(16);
				set_operand_a(bits[15:0]);
				send_random_request(waits);
			end
			for (int j = 0; j < burst; j++)
				read_and_check_result();
		end

		// Back-pressure from back to back op writes with one operand A
		bits = random_bits(16);
		set_operand_a(bits[15:0]);
		for (int i = 0; i < 11; i++)
			send_random_request(waits);
		// Two pops release the credit and the pipeline refills in a burst
		read_and_check_result();
		read_and_check_result();
		send_random_request(waits);
		if (waits == 0)
		begin
			$display("Error at %0t: write to the full request FIFO saw no wait state", $time);
			abort_run();
		end
		send_random_request(waits);
		send_random_request(waits);
		read_status(stat);
		check_stat(stat, 1'b0, 1'b1, 1'b0, 1'b1);
		for (int i = 0; i < 12; i++)
			read_and_check_result();
		read_status(stat);
		check_stat(stat, 1'b1, 1'b0, 1'b1, 1'b0);

		// Flush with requests queued and in flight
		bits = random_bits(16);
		set_operand_a(bits[15:0]);
		for (int i = 0; i < 5; i++)
			send_random_request(waits);
		bus_access(1'b1, `VU_ADR_CTRL, 32'h1, bits, waits);
		read_status(stat);
		check_stat(stat, 1'b1, 1'b0, 1'b1, 1'b0);
		model_q.delete();
		send_random_request(waits);
		read_and_check_result();
		check_empty_read();

		// Operand A kept across op writes of all four ops
		bits = random_bits(16);
		set_operand_a(bits[15:0]);
		op = OP_ADD;
		for (int i = 0; i < 4; i++)
		begin
			bits = random_bits(16);
			send_request(op, bits[15:0], waits);
			op = op.next();
		end
		for (int i = 0; i < 4; i++)
			read_and_check_result();
		read_status(stat);
		check_stat(stat, 1'b1, 1'b0, 1'b1, 1'b0);

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/vu_pkg.sv
source/sram_1r1w.sv
fifo/sync_fifo.sv
source/wb_slave_port.sv
source/alu_pipe.sv
source/vu_top.sv
bench/fifo_assert.sv
bench/vu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the vector-lane unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f all.f --top-module vu_tb -Mdir obj_dir -o vu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/vu_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation ended with status $sim_status"
	exit 1
fi

echo "Simulation ended normally"
exit 0
